// File: lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// physical address width
`define LSU_ADDR_W 32

// bus and register data width
`define LSU_DATA_W 32

// issue lanes feeding M1
`define LSU_LANES 2

// one strobe bit per data byte
`define LSU_STRB_W 4

`endif

// File: lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

	// access size of a memory operation
	typedef enum logic [1:0] {
		MEM_WORD = 2'd0,
		MEM_HALF = 2'd1,
		MEM_BYTE = 2'd2
	} mem_type_t;

	// extension applied to a narrow load
	typedef enum logic {
		MEM_UNSIGNED = 1'b0,
		MEM_SIGNED   = 1'b1
	} mem_sign_t;

	// request as held in M1 and M2
	typedef struct packed {
		logic                   valid;
		logic                   write;
		logic                   lane;
		mem_type_t              mtype;
		mem_sign_t              sign;
		logic [`LSU_ADDR_W-1:0] addr;
	} stage_req_t;

endpackage

// File: lsu_req_stage.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_req_stage
	import lsu_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [`LSU_LANES-1:0]                  mem_valid_i,
	input  logic [`LSU_LANES-1:0]                  mem_write_i,
	input  mem_type_t [`LSU_LANES-1:0]             mem_type_i,
	input  mem_sign_t [`LSU_LANES-1:0]             mem_sign_i,
	input  logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] vaddr_i,
	input  logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] paddr_i,
	input  logic                                   busy_i,
	input  logic                                   stall_i,
	input  logic                                   xfer_done_i,
	output stage_req_t                             m2_req_o
);

	stage_req_t m1_d;
	stage_req_t m1_q;
	stage_req_t m2_q;
	logic       advance;
	logic       sel;

	// both stages move only when nothing holds the pipe
	assign advance = ~busy_i & ~stall_i;

	// lane 1 wins when both lanes issue
	assign sel = mem_valid_i[1];

	always_comb begin
		m1_d.valid = |mem_valid_i;
		m1_d.write = mem_write_i[sel];
		m1_d.lane  = sel;
		m1_d.mtype = mem_type_i[sel];
		m1_d.sign  = mem_sign_i[sel];
		m1_d.addr  = vaddr_i[sel];
	end

	// M1 register
	always_ff @(posedge clk) begin
		if (rst_n) begin
			m1_q <= '0;
		end else if (advance) begin
			m1_q <= m1_d;
		end
	end

	// M2 register, paddr arrives one stage after vaddr
	always_ff @(posedge clk) begin
		if (rst_n) begin
			m2_q <= '0;
		end else if (xfer_done_i) begin
			m2_q.valid <= 1'b0;
		end else if (advance) begin
			m2_q.valid <= m1_q.valid;
			m2_q.write <= m1_q.write;
			m2_q.lane  <= m1_q.lane;
			m2_q.mtype <= m1_q.mtype;
			m2_q.sign  <= m1_q.sign;
			m2_q.addr  <= paddr_i[m1_q.lane];
		end
	end

	assign m2_req_o = m2_q;

endmodule

// File: lsu_bus_seq.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_bus_seq
	import lsu_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  stage_req_t                             m2_req_i,
	input  logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] wdata_i,
	output logic                                   bus_valid_o,
	output logic                                   bus_write_o,
	output logic [`LSU_ADDR_W-1:0]                 bus_addr_o,
	output logic [`LSU_STRB_W-1:0]                 bus_strb_o,
	output logic [`LSU_DATA_W-1:0]                 bus_wdata_o,
	output logic                                   bus_data_ok_o,
	output logic                                   bus_data_last_o,
	input  logic                                   bus_ready_i,
	input  logic                                   bus_data_ok_i,
	input  logic                                   bus_data_last_i,
	output logic                                   xfer_done_o,
	output logic                                   busy_o
);

	localparam logic [2:0] ST_IDLE = 3'b001;
	localparam logic [2:0] ST_ADDR = 3'b010;
	localparam logic [2:0] ST_DATA = 3'b100;

	logic [2:0] state_q;
	logic [2:0] state_d;
	logic [1:0] off;
	logic       last;

	assign off = m2_req_i.addr[1:0];

	// writes end on our own last, reads on the slave's
	assign last = m2_req_i.write ? bus_data_last_o : bus_data_last_i;
	assign xfer_done_o = last & bus_data_ok_o & bus_data_ok_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (m2_req_i.valid) begin
					state_d = ST_ADDR;
				end
			end
			ST_ADDR: begin
				if (bus_ready_i) begin
					state_d = ST_DATA;
				end
			end
			ST_DATA: begin
				if (xfer_done_o) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// a request waiting in M2 already counts as busy
	assign busy_o = (state_q != ST_IDLE) | m2_req_i.valid;

	// request phase, fields come straight from M2 and hold with it
	assign bus_valid_o = (state_q == ST_ADDR);
	assign bus_write_o = m2_req_i.write;
	assign bus_addr_o  = m2_req_i.addr;

	// data phase is a single beat
	assign bus_data_ok_o   = (state_q == ST_DATA);
	assign bus_data_last_o = (state_q == ST_DATA);

	assign bus_wdata_o = wdata_i[m2_req_i.lane] << {off, 3'b000};

	always_comb begin
		case (m2_req_i.mtype)
			MEM_WORD: begin
				bus_strb_o = {`LSU_STRB_W{1'b1}};
			end
			MEM_HALF: begin
				bus_strb_o = `LSU_STRB_W'(2'b11) << {off[1], 1'b0};
			end
			MEM_BYTE: begin
				bus_strb_o = `LSU_STRB_W'(1'b1) << off;
			end
			default: begin
				bus_strb_o = '0;
			end
		endcase
	end

endmodule

// File: lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_load_align
	import lsu_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   xfer_done_i,
	input  logic                                   req_write_i,
	input  mem_type_t                              req_type_i,
	input  mem_sign_t                              req_sign_i,
	input  logic [1:0]                             req_off_i,
	input  logic [`LSU_DATA_W-1:0]                 bus_rdata_i,
	output logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] rdata_o,
	output logic                                   ld_done_o
);

	logic                   rd_done;
	logic                   sext;
	logic [`LSU_DATA_W-1:0] shifted;
	logic [`LSU_DATA_W-1:0] ext;
	logic [`LSU_DATA_W-1:0] rdata_q;

	assign rd_done = xfer_done_i & ~req_write_i;
	assign sext    = (req_sign_i == MEM_SIGNED);

	// move the addressed byte or half down to bit 0
	assign shifted = bus_rdata_i >> {req_off_i, 3'b000};

	always_comb begin
		case (req_type_i)
			MEM_BYTE: begin
				ext = {{(`LSU_DATA_W-8){sext & shifted[7]}}, shifted[7:0]};
			end
			MEM_HALF: begin
				ext = {{(`LSU_DATA_W-16){sext & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				ext = shifted;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_done) begin
			rdata_q <= ext;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			ld_done_o <= 1'b0;
		end else begin
			ld_done_o <= rd_done;
		end
	end

	// same result to every lane
	assign rdata_o = {`LSU_LANES{rdata_q}};

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [`LSU_LANES-1:0]                  mem_valid_i,
	input  logic [`LSU_LANES-1:0]                  mem_write_i,
	input  mem_type_t [`LSU_LANES-1:0]             mem_type_i,
	input  mem_sign_t [`LSU_LANES-1:0]             mem_sign_i,
	input  logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] vaddr_i,
	input  logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] paddr_i,
	input  logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] wdata_i,
	input  logic                                   stall_i,
	output logic                                   bus_valid_o,
	output logic                                   bus_write_o,
	output logic [`LSU_ADDR_W-1:0]                 bus_addr_o,
	output logic [`LSU_STRB_W-1:0]                 bus_strb_o,
	output logic [`LSU_DATA_W-1:0]                 bus_wdata_o,
	output logic                                   bus_data_ok_o,
	output logic                                   bus_data_last_o,
	input  logic                                   bus_ready_i,
	input  logic                                   bus_data_ok_i,
	input  logic                                   bus_data_last_i,
	input  logic [`LSU_DATA_W-1:0]                 bus_rdata_i,
	output logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] rdata_o,
	output logic                                   ld_done_o,
	output logic                                   busy_o
);

	stage_req_t m2_req;
	logic       xfer_done;

	lsu_req_stage i_req_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_valid_i (mem_valid_i),
		.mem_write_i (mem_write_i),
		.mem_type_i  (mem_type_i),
		.mem_sign_i  (mem_sign_i),
		.vaddr_i     (vaddr_i),
		.paddr_i     (paddr_i),
		.busy_i      (busy_o),
		.stall_i     (stall_i),
		.xfer_done_i (xfer_done),
		.m2_req_o    (m2_req)
	);

	lsu_bus_seq i_bus_seq (
		.clk             (clk),
		.rst_n           (rst_n),
		.m2_req_i        (m2_req),
		.wdata_i         (wdata_i),
		.bus_valid_o     (bus_valid_o),
		.bus_write_o     (bus_write_o),
		.bus_addr_o      (bus_addr_o),
		.bus_strb_o      (bus_strb_o),
		.bus_wdata_o     (bus_wdata_o),
		.bus_data_ok_o   (bus_data_ok_o),
		.bus_data_last_o (bus_data_last_o),
		.bus_ready_i     (bus_ready_i),
		.bus_data_ok_i   (bus_data_ok_i),
		.bus_data_last_i (bus_data_last_i),
		.xfer_done_o     (xfer_done),
		.busy_o          (busy_o)
	);

	// M2 still holds the request in the completion cycle
	lsu_load_align i_load_align (
		.clk         (clk),
		.rst_n       (rst_n),
		.xfer_done_i (xfer_done),
		.req_write_i (m2_req.write),
		.req_type_i  (m2_req.mtype),
		.req_sign_i  (m2_req.sign),
		.req_off_i   (m2_req.addr[1:0]),
		.bus_rdata_i (bus_rdata_i),
		.rdata_o     (rdata_o),
		.ld_done_o   (ld_done_o)
	);

endmodule

// File: lsu_mem_model.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_mem_model (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   bus_valid_i,
	input  logic                   bus_write_i,
	input  logic [`LSU_ADDR_W-1:0] bus_addr_i,
	input  logic [`LSU_STRB_W-1:0] bus_strb_i,
	input  logic [`LSU_DATA_W-1:0] bus_wdata_i,
	input  logic                   bus_data_ok_i,
	output logic                   bus_ready_o,
	output logic                   bus_data_ok_o,
	output logic                   bus_data_last_o,
	output logic [`LSU_DATA_W-1:0] bus_rdata_o
);

	logic [`LSU_DATA_W-1:0] mem [0:255];
	logic                   pend;
	logic                   wr_q;
	logic [`LSU_ADDR_W-1:0] addr_q;
	logic [`LSU_STRB_W-1:0] strb_q;
	logic [1:0]             cnt;
	logic [31:0]            a;

	// fill with a pattern built from the full byte address
	initial begin
		for (int i = 0; i < 256; i++) begin
			a = i * 4;
			mem[i] = {~a[15:0], a[15:0]} ^ (a * 32'h0101_0101);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			pend        <= 1'b0;
			bus_ready_o <= 1'b0;
			bus_data_ok_o <= 1'b0;
			cnt         <= '0;
		end else if (!pend) begin
			if (bus_valid_i && bus_ready_o) begin
				pend        <= 1'b1;
				bus_ready_o <= 1'b0;
				wr_q        <= bus_write_i;
				addr_q      <= bus_addr_i;
				strb_q      <= bus_strb_i;
				cnt         <= 2'($urandom_range(3, 0));
			end else begin
				bus_ready_o <= 1'($urandom_range(1, 0));
			end
		end else if (bus_data_ok_o && bus_data_ok_i) begin
			// single beat done, apply masked write
			if (wr_q) begin
				for (int b = 0; b < `LSU_STRB_W; b++) begin
					if (strb_q[b]) begin
						mem[addr_q[9:2]][b*8 +: 8] <= bus_wdata_i[b*8 +: 8];
					end
				end
			end
			pend          <= 1'b0;
			bus_data_ok_o <= 1'b0;
		end else if (cnt == 2'd0) begin
			bus_data_ok_o <= 1'b1;
		end else begin
			cnt <= cnt - 2'd1;
		end
	end

	assign bus_data_last_o = bus_data_ok_o;
	assign bus_rdata_o     = mem[addr_q[9:2]];

endmodule

// File: lsu_props.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   bus_valid_o,
	input logic                   bus_ready_i,
	input logic                   bus_write_o,
	input logic [`LSU_ADDR_W-1:0] bus_addr_o,
	input logic [`LSU_STRB_W-1:0] bus_strb_o,
	input logic [`LSU_DATA_W-1:0] bus_wdata_o,
	input logic                   xfer_done_o,
	input logic                   busy_o
);

	// request stays up until accepted
	valid_held: assert property (@(posedge clk) disable iff (rst_n)
		bus_valid_o && !bus_ready_i |=> bus_valid_o)
		else $error("bus_valid_o dropped before bus_ready_i");

	fields_stable: assert property (@(posedge clk) disable iff (rst_n)
		bus_valid_o && !bus_ready_i |=> $stable(bus_write_o) && $stable(bus_addr_o)
			&& $stable(bus_strb_o) && $stable(bus_wdata_o))
		else $error("request fields changed while waiting for bus_ready_i");

	// busy holds from M2 entry until the transfer completes
	busy_until_done: assert property (@(posedge clk) disable iff (rst_n)
		busy_o && !xfer_done_o |=> busy_o)
		else $error("busy_o dropped before the transfer completed");

endmodule

bind lsu_bus_seq lsu_props i_props (
	.clk(clk), .rst_n(rst_n), .bus_valid_o(bus_valid_o), .bus_ready_i(bus_ready_i),
	.bus_write_o(bus_write_o), .bus_addr_o(bus_addr_o), .bus_strb_o(bus_strb_o),
	.bus_wdata_o(bus_wdata_o), .xfer_done_o(xfer_done_o), .busy_o(busy_o)
);

// File: tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu
	import lsu_pkg::*;
;

	typedef struct {
		logic [1:0]  lanes;
		logic        wr;
		logic [1:0]  typ;
		logic        sgn;
		logic [31:0] addr;
		logic [31:0] wdata;
		int          stall;
		logic [31:0] exp;
	} op_t;

	logic clk;
	logic rst_n;
	logic [`LSU_LANES-1:0] mem_valid;
	logic [`LSU_LANES-1:0] mem_write;
	mem_type_t [`LSU_LANES-1:0] mem_type;
	mem_sign_t [`LSU_LANES-1:0] mem_sign;
	logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] vaddr;
	logic [`LSU_LANES-1:0][`LSU_ADDR_W-1:0] paddr;
	logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] wdata;
	logic stall;
	logic bus_valid, bus_write, bus_data_ok, bus_data_last;
	logic [`LSU_ADDR_W-1:0] bus_addr;
	logic [`LSU_STRB_W-1:0] bus_strb;
	logic [`LSU_DATA_W-1:0] bus_wdata, bus_rdata;
	logic bus_ready, slv_data_ok, slv_data_last;
	logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] rdata;
	logic ld_done, busy;

	op_t ops[$];
	logic [31:0] shadow [int];
	int xfers, lds;
	logic [31:0] hs_addr;
	logic [3:0] hs_strb;
	logic hs_write;

	lsu_top i_dut (
		.clk(clk), .rst_n(rst_n), .mem_valid_i(mem_valid), .mem_write_i(mem_write),
		.mem_type_i(mem_type), .mem_sign_i(mem_sign), .vaddr_i(vaddr), .paddr_i(paddr),
		.wdata_i(wdata), .stall_i(stall), .bus_valid_o(bus_valid), .bus_write_o(bus_write),
		.bus_addr_o(bus_addr), .bus_strb_o(bus_strb), .bus_wdata_o(bus_wdata),
		.bus_data_ok_o(bus_data_ok), .bus_data_last_o(bus_data_last),
		.bus_ready_i(bus_ready), .bus_data_ok_i(slv_data_ok),
		.bus_data_last_i(slv_data_last), .bus_rdata_i(bus_rdata), .rdata_o(rdata),
		.ld_done_o(ld_done), .busy_o(busy)
	);

	lsu_mem_model i_mem (
		.clk(clk), .rst_n(rst_n), .bus_valid_i(bus_valid), .bus_write_i(bus_write),
		.bus_addr_i(bus_addr), .bus_strb_i(bus_strb), .bus_wdata_i(bus_wdata),
		.bus_data_ok_i(bus_data_ok), .bus_ready_o(bus_ready), .bus_data_ok_o(slv_data_ok),
		.bus_data_last_o(slv_data_last), .bus_rdata_o(bus_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// transfers, load completions and the accepted request
	always @(posedge clk) begin
		if (!rst_n) begin
			if (bus_data_ok && slv_data_ok && (bus_write ? bus_data_last : slv_data_last)) begin
				xfers <= xfers + 1;
			end
			if (ld_done) begin
				lds <= lds + 1;
			end
			if (bus_valid && bus_ready) begin
				hs_addr <= bus_addr;
				hs_strb <= bus_strb;
				hs_write <= bus_write;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_op(input logic [1:0] lanes, input logic wr, input logic [1:0] typ,
			input logic sgn, input logic [31:0] addr, input logic [31:0] wd,
			input int stl, input logic [31:0] exp);
		op_t op;
		op = '{lanes, wr, typ, sgn, addr, wd, stl, exp};
		ops.push_back(op);
	endtask

	function automatic logic [3:0] strobe_for(input logic [1:0] typ, input logic [1:0] off);
		case (typ)
			2'd0: return 4'hf;
			2'd1: return off[1] ? 4'hc : 4'h3;
			default: return 4'b0001 << off;
		endcase
	endfunction

	function automatic logic [31:0] load_expect(input logic [31:0] word, input logic [1:0] typ,
			input logic sgn, input logic [1:0] off);
		logic [31:0] w;
		w = word >> (off * 8);
		if (typ == 2'd2) begin
			return {{24{sgn & w[7]}}, w[7:0]};
		end else if (typ == 2'd1) begin
			return {{16{sgn & w[15]}}, w[15:0]};
		end
		return w;
	endfunction

	task automatic run_op(input op_t op);
		int sel;
		int x0;
		int l0;
		logic [31:0] wexp;
		logic [3:0] sb;
		sel = op.lanes[1] ? 1 : 0;
		sb = strobe_for(op.typ, op.addr[1:0]);
		mem_valid = op.lanes;
		mem_write = {2{op.wr}};
		mem_type[0] = mem_type_t'(op.typ);
		mem_type[1] = mem_type_t'(op.typ);
		mem_sign[0] = mem_sign_t'(op.sgn);
		mem_sign[1] = mem_sign_t'(op.sgn);
		// decoy values on the lane that must lose
		vaddr[1-sel] = op.addr ^ 32'h40;
		wdata[1-sel] = ~op.wdata;
		vaddr[sel] = op.addr;
		wdata[sel] = op.wdata;
		paddr = {2{32'hdead_0000}};
		stall = (op.stall != 0);
		x0 = xfers;
		l0 = lds;
		for (int k = 0; k < op.stall; k++) begin
			@(posedge clk);
			#1;
			check("busy_o during stall", busy, 1'b0);
		end
		stall = 1'b0;
		@(posedge clk);
		#1;
		mem_valid = '0;
		paddr = vaddr;
		do begin
			@(posedge clk);
			#1;
		end while (!busy);
		do begin
			@(posedge clk);
			#1;
			if (busy) begin
				check("transfers before completion", xfers, x0);
			end
		end while (busy);
		@(posedge clk);
		#1;
		check("transfer count", xfers, x0 + 1);
		check("ld_done_o pulses", lds, l0 + (op.wr ? 0 : 1));
		check("bus_addr_o", hs_addr, op.addr);
		check("bus_strb_o", hs_strb, sb);
		check("bus_write_o", hs_write, op.wr);
		if (op.wr) begin
			wexp = shadow.exists(op.addr >> 2) ? shadow[op.addr >> 2] : 32'h0;
			for (int b = 0; b < 4; b++) begin
				if (sb[b]) begin
					wexp[b*8 +: 8] = (op.wdata << (op.addr[1:0] * 8)) >> (b * 8);
				end
			end
			shadow[op.addr >> 2] = wexp;
		end else begin
			wexp = load_expect(shadow[op.addr >> 2], op.typ, op.sgn, op.addr[1:0]);
			check("table expected value", op.exp, wexp);
			check("rdata_o[0]", rdata[0], wexp);
			check("rdata_o[1]", rdata[1], wexp);
		end
	endtask

	initial begin
		int n;
		void'($urandom(27229));
		rst_n = 1'b1;
		mem_valid = '0;
		mem_write = '0;
		mem_type[0] = MEM_WORD;
		mem_type[1] = MEM_WORD;
		mem_sign[0] = MEM_UNSIGNED;
		mem_sign[1] = MEM_UNSIGNED;
		vaddr = '0;
		paddr = '0;
		wdata = '0;
		stall = 1'b0;
		xfers = 0;
		lds = 0;
		hs_addr = '0;
		hs_strb = '0;
		hs_write = 1'b0;
		// lanes, write, type, sign, address, write data, stall, expected load
		add_op(2'b01, 1, 0, 0, 32'h100, 32'h1122_3344, 0, 32'h0);
		add_op(2'b10, 0, 0, 0, 32'h100, 32'h0, 2, 32'h1122_3344);
		add_op(2'b01, 1, 2, 0, 32'h101, 32'h0000_00ab, 0, 32'h0);
		add_op(2'b10, 1, 1, 0, 32'h102, 32'h0000_cdef, 1, 32'h0);
		add_op(2'b01, 0, 0, 0, 32'h100, 32'h0, 3, 32'hcdef_ab44);
		add_op(2'b10, 0, 2, 1, 32'h101, 32'h0, 0, 32'hffff_ffab);
		add_op(2'b01, 0, 2, 0, 32'h101, 32'h0, 0, 32'h0000_00ab);
		add_op(2'b10, 0, 1, 1, 32'h102, 32'h0, 0, 32'hffff_cdef);
		add_op(2'b01, 0, 1, 0, 32'h102, 32'h0, 1, 32'h0000_cdef);
		add_op(2'b10, 0, 2, 1, 32'h100, 32'h0, 0, 32'h0000_0044);
		add_op(2'b11, 1, 0, 0, 32'h104, 32'h5a5a_f00d, 0, 32'h0);
		add_op(2'b11, 0, 0, 0, 32'h104, 32'h0, 2, 32'h5a5a_f00d);
		add_op(2'b11, 1, 2, 0, 32'h107, 32'h0000_0080, 1, 32'h0);
		add_op(2'b01, 0, 2, 1, 32'h107, 32'h0, 0, 32'hffff_ff80);
		add_op(2'b11, 0, 1, 0, 32'h100, 32'h0, 0, 32'h0000_ab44);
		add_op(2'b10, 1, 1, 0, 32'h104, 32'h0000_7ffe, 0, 32'h0);
		add_op(2'b11, 0, 1, 1, 32'h104, 32'h0, 0, 32'h0000_7ffe);
		add_op(2'b11, 0, 0, 0, 32'h104, 32'h0, 4, 32'h805a_7ffe);
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b0;
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			#1;
			check("busy_o after reset", busy, 1'b0);
			check("ld_done_o after reset", ld_done, 1'b0);
			check("bus_valid_o after reset", bus_valid, 1'b0);
		end
		n = ops.size();
		for (int i = 0; i < n; i++) begin
			run_op(ops[i]);
		end
		$display("Everything OK");
		$finish;
	end

	// limit scales with the table length
	initial begin
		#1;
		repeat (ops.size() * 64 + 16) @(posedge clk);
		$display("Timeout: the operation table did not finish in time");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: sim.f
+incdir+.
lsu_pkg.sv
lsu_req_stage.sv
lsu_bus_seq.sv
lsu_load_align.sv
lsu_top.sv
lsu_mem_model.sv
lsu_props.sv
tb_lsu.sv
